/* design/dram_macros.svh */
// geometry, widths and timing constants of the DRAM model
// shared by the packages and the RTL

`ifndef DRAM_MACROS_SVH
`define DRAM_MACROS_SVH

// data word
`define DRAM_DATA_WIDTH 32

// word address fields, column in the low bits
`define DRAM_COL_BITS 3
`define DRAM_BANK_BITS 2
`define DRAM_ROW_BITS 5
`define DRAM_ADDR_WIDTH 10 // row + bank + col

// cycles from acceptance to read data ready
`define DRAM_LAT_HIT 2 // row already open
`define DRAM_LAT_EMPTY 4 // bank closed, activate only
`define DRAM_LAT_MISS 6 // precharge then activate

// outstanding reads, also the depth of the route FIFO
`define DRAM_RD_DEPTH 4

`endif // DRAM_MACROS_SVH

/* design/dram_pkg.sv */
// memory side types: address union, request and response structs,
// bank access classification

`include "dram_macros.svh"

package dram_pkg;

    // row / bank / column view of a word address
    typedef struct packed {
        logic [`DRAM_ROW_BITS-1:0]  row;
        logic [`DRAM_BANK_BITS-1:0] bank;
        logic [`DRAM_COL_BITS-1:0]  col; // low bits
    } dram_addr_fields_t;

    // same word, flat or split into fields
    typedef union packed {
        logic [`DRAM_ADDR_WIDTH-1:0] flat;
        dram_addr_fields_t           fields;
    } dram_addr_u;

    typedef struct packed {
        logic                        we;
        dram_addr_u                  addr;
        logic [`DRAM_DATA_WIDTH-1:0] wdata;
    } dram_req_t;

    typedef struct packed {
        logic [`DRAM_DATA_WIDTH-1:0] rdata;
    } dram_rsp_t;

    // row buffer state seen by an access
    typedef enum logic [1:0] {
        BANK_HIT,
        BANK_EMPTY,
        BANK_MISS
    } bank_access_e;

endpackage

/* design/bus_pkg.sv */
// requester side types: port count, port index, per-port request
// and response structs

`include "dram_macros.svh"

package bus_pkg;

    localparam int NUM_PORTS = 2;

    typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

    // request as issued by a requester port
    typedef struct packed {
        logic                        we;
        logic [`DRAM_ADDR_WIDTH-1:0] addr; // word address
        logic [`DRAM_DATA_WIDTH-1:0] wdata;
    } port_req_t;

    // read data back to the port
    typedef struct packed {
        logic [`DRAM_DATA_WIDTH-1:0] rdata;
    } port_rsp_t;

endpackage

/* design/dram_bank_timing.sv */
// per-bank open row tracking
// classifies each access as row hit, closed bank or row conflict

`timescale 1ns/1ps

`include "dram_macros.svh"

module dram_bank_timing import dram_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         access_i, // accepted request this cycle
    input  dram_addr_u   addr_i,
    output bank_access_e kind_o
);

    localparam int num_banks = 1 << `DRAM_BANK_BITS;

    logic [num_banks-1:0]      open_q;            // bank has an active row
    logic [`DRAM_ROW_BITS-1:0] row_q [num_banks]; // row held in each row buffer

    logic [`DRAM_BANK_BITS-1:0] bank;
    logic [`DRAM_ROW_BITS-1:0]  row;

    assign bank = addr_i.fields.bank;
    assign row  = addr_i.fields.row;

    // classification uses the state before this access
    always_comb begin
        if (!open_q[bank]) begin
            kind_o = BANK_EMPTY;
        end else if (row_q[bank] == row) begin
            kind_o = BANK_HIT;
        end else begin
            kind_o = BANK_MISS;
        end
    end

    // all banks closed after reset
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            open_q <= '0;
        end else if (access_i) begin
            open_q[bank] <= 1'b1;
        end
    end

    // any access leaves its row open, a conflict replaces the old row
    always_ff @(posedge clk_i) begin
        if (access_i) begin
            row_q[bank] <= row;
        end
    end

endmodule

/* design/dram_model.sv */
// DRAM model: word storage, request acceptance and an in-order
// completion queue of read data with per-entry countdowns

`timescale 1ns/1ps

`include "dram_macros.svh"

module dram_model import dram_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    // request
    input  logic      req_valid_i,
    output logic      req_ready_o,
    input  dram_req_t req_i,
    // read response
    output logic      rsp_valid_o,
    input  logic      rsp_ready_i,
    output dram_rsp_t rsp_o
);

    localparam int depth = `DRAM_RD_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int occ_w = $clog2(depth + 1);
    localparam int cnt_w = $clog2(`DRAM_LAT_MISS + 1); // miss is the longest wait
    localparam int words = 1 << `DRAM_ADDR_WIDTH;

    typedef logic [ptr_w-1:0] ptr_t;
    typedef logic [cnt_w-1:0] cnt_t;

    // storage, zero from time zero
    logic [`DRAM_DATA_WIDTH-1:0] mem_q [words] = '{default: '0};

    // completion queue
    logic [`DRAM_DATA_WIDTH-1:0] data_q [depth];
    cnt_t                        cnt_q  [depth]; // cycles left until data ready
    ptr_t                        head_q, tail_q;
    logic [occ_w-1:0]            occ_q;

    bank_access_e kind;
    cnt_t         lat;
    logic         req_hs, rd_push, wr_en, rsp_hs;

    assign req_ready_o = (occ_q != occ_w'(depth)); // writes wait too
    assign req_hs      = req_valid_i && req_ready_o;
    assign rd_push     = req_hs && !req_i.we;
    assign wr_en       = req_hs && req_i.we;

    // head leaves once its countdown has run out
    assign rsp_valid_o = (occ_q != '0) && (cnt_q[head_q] == '0);
    assign rsp_hs      = rsp_valid_o && rsp_ready_i;
    assign rsp_o.rdata = data_q[head_q];

    dram_bank_timing i_bank_timing (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .access_i (req_hs),
        .addr_i   (req_i.addr),
        .kind_o   (kind)
    );

    always_comb begin
        unique case (kind)
            BANK_HIT:   lat = cnt_t'(`DRAM_LAT_HIT);
            BANK_EMPTY: lat = cnt_t'(`DRAM_LAT_EMPTY);
            default:    lat = cnt_t'(`DRAM_LAT_MISS);
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[req_i.addr.flat] <= req_i.wdata;
        end
    end

    // entries count down every cycle, new read lands at the tail
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < depth; i++) begin
            if (cnt_q[i] != '0) begin
                cnt_q[i] <= cnt_q[i] - 1'b1;
            end
        end
        if (rd_push) begin
            cnt_q[tail_q]  <= lat;
            data_q[tail_q] <= mem_q[req_i.addr.flat]; // data fixed at acceptance
        end
    end

    // queue pointers and occupancy
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            head_q <= '0;
            tail_q <= '0;
            occ_q  <= '0;
        end else begin
            if (rd_push) begin
                tail_q <= (tail_q == ptr_t'(depth - 1)) ? '0 : tail_q + 1'b1;
            end
            if (rsp_hs) begin
                head_q <= (head_q == ptr_t'(depth - 1)) ? '0 : head_q + 1'b1;
            end
            case ({rd_push, rsp_hs})
                2'b10:   occ_q <= occ_q + 1'b1;
                2'b01:   occ_q <= occ_q - 1'b1;
                default: occ_q <= occ_q; // none, or push and pop together
            endcase
        end
    end

endmodule

/* design/mem_arbiter.sv */
// round-robin arbiter from the requester ports onto the DRAM model
// read responses routed back through a FIFO of port indices

`timescale 1ns/1ps

`include "dram_macros.svh"

module mem_arbiter import bus_pkg::*; import dram_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    // requester ports
    input  logic       [NUM_PORTS-1:0]  port_req_valid_i,
    output logic       [NUM_PORTS-1:0]  port_req_ready_o,
    input  port_req_t  [NUM_PORTS-1:0]  port_req_i,
    output logic       [NUM_PORTS-1:0]  port_rsp_valid_o,
    input  logic       [NUM_PORTS-1:0]  port_rsp_ready_i,
    output port_rsp_t  [NUM_PORTS-1:0]  port_rsp_o,
    // DRAM side
    output logic                        mem_req_valid_o,
    input  logic                        mem_req_ready_i,
    output dram_req_t                   mem_req_o,
    input  logic                        mem_rsp_valid_i,
    output logic                        mem_rsp_ready_o,
    input  dram_rsp_t                   mem_rsp_i
);

    localparam int depth = `DRAM_RD_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    typedef logic [ptr_w-1:0] ptr_t;

    port_idx_t        last_q;              // port granted last
    port_idx_t        route_q [depth];     // issuing port of each read in flight
    ptr_t             wr_q, rd_q;
    logic [cnt_w-1:0] fill_q;

    logic [NUM_PORTS-1:0] eligible;
    logic                 gnt_valid, route_full, route_empty, push, pop;
    port_idx_t            gnt_idx, head;

    assign route_full  = (fill_q == cnt_w'(depth));
    assign route_empty = (fill_q == '0);
    assign head        = route_q[rd_q];

    // a read waits while the route FIFO is full
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            eligible[p] = port_req_valid_i[p] && (port_req_i[p].we || !route_full);
        end
    end

    // search starts one past the last grant
    always_comb begin
        port_idx_t cand;
        gnt_valid = 1'b0;
        gnt_idx   = last_q;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = port_idx_t'((int'(last_q) + i) % NUM_PORTS);
            if (!gnt_valid && eligible[cand]) begin
                gnt_valid = 1'b1;
                gnt_idx   = cand;
            end
        end
    end

    assign mem_req_valid_o     = gnt_valid;
    assign mem_req_o.we        = port_req_i[gnt_idx].we;
    assign mem_req_o.addr.flat = port_req_i[gnt_idx].addr;
    assign mem_req_o.wdata     = port_req_i[gnt_idx].wdata;

    assign push            = mem_req_valid_o && mem_req_ready_i && !mem_req_o.we;
    assign mem_rsp_ready_o = !route_empty && port_rsp_ready_i[head]; // only the owner
    assign pop             = mem_rsp_valid_i && mem_rsp_ready_o;

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            port_req_ready_o[p] = gnt_valid && (gnt_idx == port_idx_t'(p)) && mem_req_ready_i;
            port_rsp_valid_o[p] = mem_rsp_valid_i && !route_empty
                                  && (head == port_idx_t'(p));
            port_rsp_o[p].rdata = mem_rsp_i.rdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            route_q[wr_q] <= gnt_idx;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            last_q <= port_idx_t'(NUM_PORTS - 1); // port 0 wins first
            wr_q   <= '0;
            rd_q   <= '0;
            fill_q <= '0;
        end else begin
            if (mem_req_valid_o && mem_req_ready_i) begin
                last_q <= gnt_idx;
            end
            if (push) begin
                wr_q <= (wr_q == ptr_t'(depth - 1)) ? '0 : wr_q + 1'b1;
            end
            if (pop) begin
                rd_q <= (rd_q == ptr_t'(depth - 1)) ? '0 : rd_q + 1'b1;
            end
            if (push && !pop) begin
                fill_q <= fill_q + 1'b1;
            end else if (pop && !push) begin
                fill_q <= fill_q - 1'b1;
            end
        end
    end

endmodule

/* design/dram_subsys_top.sv */
// DRAM subsystem top: two requester ports, arbiter, DRAM model

`timescale 1ns/1ps

module dram_subsys_top import bus_pkg::*; import dram_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic       [NUM_PORTS-1:0]  port_req_valid_i,
    output logic       [NUM_PORTS-1:0]  port_req_ready_o,
    input  port_req_t  [NUM_PORTS-1:0]  port_req_i,
    output logic       [NUM_PORTS-1:0]  port_rsp_valid_o,
    input  logic       [NUM_PORTS-1:0]  port_rsp_ready_i,
    output port_rsp_t  [NUM_PORTS-1:0]  port_rsp_o
);

    // arbiter to model
    logic      mem_req_valid, mem_req_ready;
    dram_req_t mem_req;
    logic      mem_rsp_valid, mem_rsp_ready;
    dram_rsp_t mem_rsp;

    mem_arbiter i_arbiter (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .port_req_valid_i (port_req_valid_i),
        .port_req_ready_o (port_req_ready_o),
        .port_req_i       (port_req_i),
        .port_rsp_valid_o (port_rsp_valid_o),
        .port_rsp_ready_i (port_rsp_ready_i),
        .port_rsp_o       (port_rsp_o),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_ready_i  (mem_req_ready),
        .mem_req_o        (mem_req),
        .mem_rsp_valid_i  (mem_rsp_valid),
        .mem_rsp_ready_o  (mem_rsp_ready),
        .mem_rsp_i        (mem_rsp)
    );

    dram_model i_dram (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_valid_i (mem_req_valid),
        .req_ready_o (mem_req_ready),
        .req_i       (mem_req),
        .rsp_valid_o (mem_rsp_valid),
        .rsp_ready_i (mem_rsp_ready),
        .rsp_o       (mem_rsp)
    );

endmodule

/* bench/tb_dram_subsys.sv */
// testbench for the DRAM subsystem with clock, reset, LFSR stimulus,
// shadow memory with per-port expected read data and checks

`timescale 1ns/1ps

`include "dram_macros.svh"

module tb_dram_subsys import bus_pkg::*; ();

    localparam int num_trans     = 2000;
    localparam int words         = 1 << `DRAM_ADDR_WIDTH;
    localparam int exp_depth     = 16;
    localparam int req_timeout   = 1000; // cycles a request may wait for ready
    localparam int rsp_timeout   = 1000; // cycles a port may wait for its next read data
    localparam int drain_timeout = 2000;
    localparam int run_timeout   = 100000;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic      [NUM_PORTS-1:0] req_valid, req_ready, rsp_valid, rsp_ready;
    port_req_t [NUM_PORTS-1:0] req;
    port_rsp_t [NUM_PORTS-1:0] rsp;

    logic [31:0]                 lfsr;
    logic [`DRAM_DATA_WIDTH-1:0] shadow [words];              // reference memory
    logic [`DRAM_DATA_WIDTH-1:0] exp_data [NUM_PORTS][exp_depth];
    int                          exp_head [NUM_PORTS];
    int                          exp_cnt [NUM_PORTS];         // reads in flight per port
    int                          req_wait [NUM_PORTS];
    int                          rsp_wait [NUM_PORTS];
    int                          stall [NUM_PORTS];           // cycles of back-pressure left
    logic [NUM_PORTS-1:0]        took;                        // handshake at the coming edge
    logic [NUM_PORTS-1:0]        held;
    logic [`DRAM_DATA_WIDTH-1:0] held_data [NUM_PORTS];
    int                          accepted, last_port, cycles;
    logic                        have_last, draining;

    dram_subsys_top dut_i (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .port_req_valid_i (req_valid),
        .port_req_ready_o (req_ready),
        .port_req_i       (req),
        .port_rsp_valid_o (rsp_valid),
        .port_rsp_ready_i (rsp_ready),
        .port_rsp_o       (rsp)
    );

    always #50 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]}; // one step per bit
        end
    endtask

    function automatic int outstanding_reads();
        int sum;
        sum = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            sum += exp_cnt[p];
        end
        return sum;
    endfunction

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_values(input string name, input logic [63:0] got,
                                  input logic [63:0] expected);
        if (got !== expected) begin
            $display("FAIL at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
            abort_run();
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        abort_run();
    endtask

    // new inputs on the rising edge
    task automatic drive_cycle();
        logic [31:0] r;
        port_req_t   nreq;
        logic        nvalid;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!req_valid[p] || took[p]) begin // payload stays until its handshake
                took[p] = 1'b0;
                nreq    = '0;
                nvalid  = 1'b0;
                if (accepted < num_trans) begin
                    take_bits(2, r);
                    nvalid = (r[1:0] != 2'b00);
                end
                if (nvalid) begin
                    take_bits(1, r);
                    nreq.we = r[0];
                    take_bits(`DRAM_ADDR_WIDTH, r);
                    nreq.addr = r[`DRAM_ADDR_WIDTH-1:0];
                    take_bits(1, r);
                    if (r[0]) begin
                        nreq.addr[`DRAM_ADDR_WIDTH-1 -: 3] = '0; // rows 0..3 only for more hits
                    end
                    take_bits(`DRAM_DATA_WIDTH, r);
                    nreq.wdata = r;
                end
                req_valid[p] <= nvalid;
                req[p]       <= nreq;
            end
            if (draining) begin
                rsp_ready[p] <= 1'b1;
            end else if (stall[p] > 0) begin
                stall[p]--;
                rsp_ready[p] <= 1'b0;
            end else begin
                take_bits(4, r);
                if (r[3:0] == 4'h0) begin
                    take_bits(6, r);
                    stall[p]      = int'(r[5:0]); // long stretch of back-pressure
                    rsp_ready[p] <= 1'b0;
                end else begin
                    rsp_ready[p] <= (r[1:0] != 2'b00);
                end
            end
        end
    endtask

    // sampled at the falling edge for handshakes at the next rising edge
    task automatic observe_cycle();
        int                          outstanding;
        logic [NUM_PORTS-1:0]        exp_ready;
        logic [`DRAM_DATA_WIDTH-1:0] expected;
        outstanding = outstanding_reads();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (held[p]) begin
                compare_values($sformatf("port_rsp_valid_o[%0d]", p), rsp_valid[p], 1'b1);
                compare_values($sformatf("port_rsp_o[%0d].rdata", p), rsp[p].rdata,
                               held_data[p]);
            end
            held[p]      = rsp_valid[p] && !rsp_ready[p];
            held_data[p] = rsp[p].rdata;
            if (rsp_valid[p] && rsp_ready[p]) begin
                if (exp_cnt[p] == 0) begin
                    report_error($sformatf("port %0d got a response with no read pending", p));
                end
                expected    = exp_data[p][exp_head[p]];
                exp_head[p] = (exp_head[p] + 1) % exp_depth;
                exp_cnt[p]--;
                compare_values($sformatf("port_rsp_o[%0d].rdata", p), rsp[p].rdata, expected);
                rsp_wait[p] = 0;
            end else if (exp_cnt[p] != 0) begin
                rsp_wait[p]++;
                if (rsp_wait[p] > rsp_timeout) begin
                    report_error($sformatf("port %0d waited too long for read data", p));
                end
            end else begin
                rsp_wait[p] = 0;
            end
        end

        // model full refuses all, otherwise round robin
        exp_ready = '0;
        if (outstanding < `DRAM_RD_DEPTH) begin
            if (req_valid == '1 && have_last) begin
                exp_ready[(last_port + 1) % NUM_PORTS] = 1'b1;
            end else if (req_valid == '1) begin
                // first grant may go either way, but one port must win
                compare_values("port_req_ready_o grants", $countones(req_ready), 1);
                exp_ready = req_ready;
            end else begin
                exp_ready = req_valid;
            end
        end
        compare_values("port_req_ready_o one-hot", (req_ready & (req_ready - 1'b1)) == '0, 1'b1);
        compare_values("port_req_ready_o", req_ready, exp_ready);

        for (int p = 0; p < NUM_PORTS; p++) begin
            if (req_valid[p] && req_ready[p]) begin
                took[p]   = 1'b1;
                accepted++;
                last_port = p;
                have_last = 1'b1;
                if (req[p].we) begin
                    shadow[req[p].addr] = req[p].wdata;
                end else begin
                    if (exp_cnt[p] == exp_depth) begin
                        report_error($sformatf("too many reads pending on port %0d", p));
                    end
                    exp_data[p][(exp_head[p] + exp_cnt[p]) % exp_depth] = shadow[req[p].addr];
                    exp_cnt[p]++;
                end
                req_wait[p] = 0;
            end else if (req_valid[p]) begin
                req_wait[p]++;
                if (req_wait[p] > req_timeout) begin
                    report_error($sformatf("port %0d request was never accepted", p));
                end
            end
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        req_valid = '0;
        req       = '0;
        rsp_ready = '0;
        lfsr      = 32'h42ac7b21;
        took      = '0;
        held      = '0;
        accepted  = 0;
        last_port = 0;
        have_last = 1'b0;
        draining  = 1'b0;
        cycles    = 0;
        for (int a = 0; a < words; a++) begin
            shadow[a] = '0; // unwritten words read as zero
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_head[p] = 0;
            exp_cnt[p]  = 0;
            req_wait[p] = 0;
            rsp_wait[p] = 0;
            stall[p]    = 0;
        end

        // no response may show during the 16 reset cycles
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i == 15) begin
                rst_n <= 1'b1;
            end
            @(negedge clk);
            compare_values("port_rsp_valid_o", rsp_valid, '0);
        end

        while (accepted < num_trans) begin
            @(posedge clk);
            drive_cycle();
            @(negedge clk);
            observe_cycle();
            cycles++;
            if (cycles > run_timeout) begin
                report_error("the run did not reach its transaction count in time");
            end
        end

        // stop issuing and release back-pressure
        draining = 1'b1;
        cycles   = 0;
        while (req_valid != '0 || outstanding_reads() != 0) begin
            @(posedge clk);
            drive_cycle();
            @(negedge clk);
            observe_cycle();
            cycles++;
            if (cycles > drain_timeout) begin
                report_error("pending requests or read data did not drain");
            end
        end

        // a stray response in this quiet window is an error
        repeat (20) begin
            @(posedge clk);
            drive_cycle();
            @(negedge clk);
            observe_cycle();
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+design
design/dram_pkg.sv
design/bus_pkg.sv
design/dram_bank_timing.sv
design/dram_model.sv
design/mem_arbiter.sv
design/dram_subsys_top.sv
bench/tb_dram_subsys.sv

/* Bender.yml */
package:
  name: dram_subsys

sources:
  # design, in compile order
  - include_dirs:
      - design
    files:
      - design/dram_pkg.sv
      - design/bus_pkg.sv
      - design/dram_bank_timing.sv
      - design/dram_model.sv
      - design/mem_arbiter.sv
      - design/dram_subsys_top.sv

  # testbench
  - target: test
    include_dirs:
      - design
    files:
      - bench/tb_dram_subsys.sv
